/* test/axi_mem_tests.txt */
# kind id addr burst len data0 strb, all hex; burst 0 FIXED, 1 INCR, 2 WRAP; len is beats-1
# Write beat k carries data0+k with strb; reads ignore data0 and strb
# Never-written words read as the fill pattern
R 1 0100 1 3 00000000 0
# INCR write then read back
W 2 0000 1 3 11110000 f
R 3 0000 1 3 00000000 0
# Partial strobes merge with fill bytes
W 4 0040 1 1 aabbccdd 5
R 5 0040 1 1 00000000 0
W 6 0004 1 0 55667788 c
R 7 0000 1 3 00000000 0
# WRAP from mid-window, checked by INCR and WRAP reads
W 8 0088 2 3 22220000 f
R 9 0080 1 3 00000000 0
R a 0088 2 3 00000000 0
W b 0104 2 1 66660000 f
R c 0100 1 3 00000000 0
# FIXED burst keeps only the last beat
W d 00c0 0 3 33330000 f
R e 00c0 1 1 00000000 0
# Long bursts under random ready stalls
W f 0200 1 f 44440000 f
R 0 0200 1 f 00000000 0
R 1 01f8 1 3 00000000 0

/* filelist.f */
src/axi_mem_pkg.sv
src/axi_mem_fifo.sv
src/axi_mem_burst_addr.sv
src/axi_mem_ram.sv
src/axi_mem_wr_chan.sv
src/axi_mem_rd_chan.sv
src/axi_mem.sv
test/axi_mem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI memory model testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module axi_mem_tb \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vaxi_mem_tb > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* test/axi_mem_tb.sv */
`timescale 1ns/1ps

module axi_mem_tb;
  import axi_mem_pkg::*;

  localparam int                CLK_PERIOD = 100;
  localparam int                MAX_TESTS  = 32;
  localparam int                MEM_BYTES  = MEM_ELS * STRB_W;
  localparam logic [DATA_W-1:0] FILL       = 32'hdeadbeef;

  logic    clk_i;
  logic    reset_i;
  ax_req_t aw_i;
  logic    aw_valid_i;
  logic    aw_ready_o;
  w_beat_t w_i;
  logic    w_valid_i;
  logic    w_last_i;
  logic    w_ready_o;
  b_resp_t b_o;
  logic    b_valid_o;
  logic    b_ready_i;
  ax_req_t ar_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  r_beat_t r_o;
  logic    r_valid_o;
  logic    r_ready_i;

  // Commands from the test file
  logic [7:0]        t_kind  [MAX_TESTS];
  ax_req_t           t_req   [MAX_TESTS];
  logic [DATA_W-1:0] t_data0 [MAX_TESTS];
  logic [STRB_W-1:0] t_strb  [MAX_TESTS];
  int                n_tests;
  // Byte image of what the memory should hold
  logic [7:0]        ref_mem [MEM_BYTES];

  axi_mem u_axi_mem (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  // ************************************************************
  // Reference model
  // ************************************************************
  function automatic logic [ADDR_W-1:0] beat_addr(input ax_req_t req, input int k);
    int nbytes;
    int base;
    int offs;
    nbytes = (int'(req.len) + 1) * STRB_W;
    base   = int'(req.addr) - (int'(req.addr) % nbytes);
    offs   = (int'(req.addr) - base + k * STRB_W) % nbytes;
    case (req.burst)
      BURST_INCR: beat_addr = ADDR_W'(int'(req.addr) + k * STRB_W);
      BURST_WRAP: beat_addr = ADDR_W'(base + offs);
      default:    beat_addr = req.addr;
    endcase
  endfunction

  function automatic int byte_idx(input logic [ADDR_W-1:0] addr, input int b);
    return (int'(addr) & ~(STRB_W - 1)) % MEM_BYTES + b;
  endfunction

  function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] word;
    for (int b = 0; b < STRB_W; b++) begin
      word[b*8 +: 8] = ref_mem[byte_idx(addr, b)];
    end
    return word;
  endfunction

  task automatic apply_write(input int t);
    logic [DATA_W-1:0] wdata;
    logic [ADDR_W-1:0] addr;
    for (int k = 0; k <= int'(t_req[t].len); k++) begin
      wdata = t_data0[t] + DATA_W'(k);
      addr  = beat_addr(t_req[t], k);
      for (int b = 0; b < STRB_W; b++) begin
        if (t_strb[t][b]) begin
          ref_mem[byte_idx(addr, b)] = wdata[b*8 +: 8];
        end
      end
    end
  endtask

  // ************************************************************
  // Checks
  // ************************************************************
  task automatic check_b(input b_resp_t got, input b_resp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error at %0t ns: B id %0h resp %0h, expected id %0h resp %0h",
                              $time, got.id, got.resp, exp.id, exp.resp));
    end
  endtask

  task automatic check_r(input r_beat_t got, input r_beat_t exp, input int k);
    if (got !== exp) begin
      stop_on_error($sformatf({"** Error at %0t ns: R beat %0d id %0h data %h resp %0h last %0b,",
                               " expected id %0h data %h resp %0h last %0b"},
                              $time, k, got.id, got.data, got.resp, got.last,
                              exp.id, exp.data, exp.resp, exp.last));
    end
  endtask

  // ************************************************************
  // Bus drivers
  // ************************************************************
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_aw(input ax_req_t req);
    idle_cycles($urandom_range(3, 0));
    aw_i       = req;
    aw_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!aw_ready_o);
    #1;
    aw_valid_i = 1'b0;
  endtask

  task automatic send_ar(input ax_req_t req);
    idle_cycles($urandom_range(2, 0));
    ar_i       = req;
    ar_valid_i = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!ar_ready_o);
    #1;
    ar_valid_i = 1'b0;
  endtask

  task automatic send_w(input int t);
    for (int k = 0; k <= int'(t_req[t].len); k++) begin
      idle_cycles($urandom_range(3, 0));
      w_i.data  = t_data0[t] + DATA_W'(k);
      w_i.strb  = t_strb[t];
      w_last_i  = (k == int'(t_req[t].len));
      w_valid_i = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!w_ready_o);
      #1;
      w_valid_i = 1'b0;
      w_last_i  = 1'b0;
    end
  endtask

  task automatic recv_b(input int t);
    b_resp_t exp;
    logic    done;
    exp.id   = t_req[t].id;
    exp.resp = 2'b00;
    done     = 1'b0;
    while (!done) begin
      b_ready_i = ($urandom_range(3, 0) != 0);
      @(posedge clk_i);
      if (b_valid_o && b_ready_i) begin
        check_b(b_o, exp);
        done = 1'b1;
      end
      #1;
    end
    b_ready_i = 1'b0;
    @(posedge clk_i);
    if (b_valid_o) begin
      stop_on_error("Write response was delivered more than once");
    end
    #1;
  endtask

  task automatic recv_r(input int t);
    r_beat_t exp;
    int      k;
    k = 0;
    while (k <= int'(t_req[t].len)) begin
      r_ready_i = ($urandom_range(3, 0) != 0);
      @(posedge clk_i);
      if (r_valid_o && r_ready_i) begin
        exp.id   = t_req[t].id;
        exp.data = ref_word(beat_addr(t_req[t], k));
        exp.resp = 2'b00;
        exp.last = (k == int'(t_req[t].len));
        check_r(r_o, exp, k);
        k++;
      end
      #1;
    end
    r_ready_i = 1'b0;
    @(posedge clk_i);
    if (r_valid_o) begin
      stop_on_error("Read data kept coming after the last beat");
    end
    #1;
  endtask

  task automatic run_write(input int t);
    fork
      send_aw(t_req[t]);
      send_w(t);
      recv_b(t);
    join
    apply_write(t);
  endtask

  task automatic run_read(input int t);
    fork
      send_ar(t_req[t]);
      recv_r(t);
    join
  endtask

  // ************************************************************
  // Test file and watchdog
  // ************************************************************
  task automatic load_tests();
    int         fd;
    int         c;
    int         n;
    int         id;
    int         addr;
    int         burst;
    int         len;
    int         data0;
    int         strb;
    logic [7:0] ch;
    fd = $fopen("test/axi_mem_tests.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open test/axi_mem_tests.txt");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      ch = 8'(c);
      if (ch == "#") begin
        // Comment runs to the end of the line
        while (c != -1 && 8'(c) != 8'h0a) begin
          c = $fgetc(fd);
        end
      end else if (ch == "W" || ch == "R") begin
        n = $fscanf(fd, "%h %h %h %h %h %h", id, addr, burst, len, data0, strb);
        if (n != 6 || n_tests >= MAX_TESTS) begin
          stop_on_error("Test file line is malformed or there are too many lines");
        end
        t_kind[n_tests]        = ch;
        t_req[n_tests].id      = ID_W'(id);
        t_req[n_tests].addr    = ADDR_W'(addr);
        t_req[n_tests].len     = LEN_W'(len);
        t_req[n_tests].burst   = burst_e'(burst);
        t_data0[n_tests]       = data0;
        t_strb[n_tests]        = STRB_W'(strb);
        n_tests++;
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic watchdog();
    #(longint'(n_tests * 200 + 10) * CLK_PERIOD);
    stop_on_error("Timeout: the DUT stopped answering before all tests were done");
  endtask

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    aw_i       = '0;
    aw_valid_i = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_i       = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    n_tests    = 0;
    void'($urandom(79120));
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = FILL[(i % STRB_W)*8 +: 8];
    end
    load_tests();
    fork
      watchdog();
    join_none
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    for (int t = 0; t < n_tests; t++) begin
      if (t_kind[t] == "W") begin
        run_write(t);
      end else begin
        run_read(t);
      end
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* src/axi_mem.sv */
`timescale 1ns/1ps

module axi_mem (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  axi_mem_pkg::ax_req_t  aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,

  input  axi_mem_pkg::w_beat_t  w_i,
  input  logic                  w_valid_i,
  input  logic                  w_last_i,
  output logic                  w_ready_o,

  output axi_mem_pkg::b_resp_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,

  input  axi_mem_pkg::ax_req_t  ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,

  output axi_mem_pkg::r_beat_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);
  import axi_mem_pkg::*;

  w_beat_t           wq_data;
  logic              wq_valid;
  logic              wq_ready;

  ax_req_t           wr_req;
  logic [LEN_W-1:0]  wr_beat;
  logic [ADDR_W-1:0] wr_beat_addr;
  ax_req_t           rd_req;
  logic [LEN_W-1:0]  rd_beat;
  logic [ADDR_W-1:0] rd_beat_addr;

  logic              ram_we;
  logic [IDX_W-1:0]  ram_widx;
  logic [STRB_W-1:0] ram_wstrb;
  logic [DATA_W-1:0] ram_wdata;
  logic [IDX_W-1:0]  ram_ridx;
  logic [DATA_W-1:0] ram_rdata;

  // ************************************************************
  // Write path
  // ************************************************************
  axi_mem_fifo u_wq (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (w_i),
    .valid_i (w_valid_i),
    .ready_o (w_ready_o),
    .data_o  (wq_data),
    .valid_o (wq_valid),
    .ready_i (wq_ready)
  );

  axi_mem_wr_chan u_wr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .aw_i        (aw_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .wq_i        (wq_data),
    .wq_valid_i  (wq_valid),
    .wq_ready_o  (wq_ready),
    .beat_addr_i (wr_beat_addr),
    .req_o       (wr_req),
    .beat_o      (wr_beat),
    .b_o         (b_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .ram_we_o    (ram_we),
    .ram_idx_o   (ram_widx),
    .ram_strb_o  (ram_wstrb),
    .ram_data_o  (ram_wdata)
  );

  axi_mem_burst_addr u_wr_addr (
    .req_i  (wr_req),
    .beat_i (wr_beat),
    .addr_o (wr_beat_addr)
  );

  // ************************************************************
  // Read path
  // ************************************************************
  axi_mem_rd_chan u_rd (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ar_i        (ar_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .beat_addr_i (rd_beat_addr),
    .req_o       (rd_req),
    .beat_o      (rd_beat),
    .ram_idx_o   (ram_ridx),
    .ram_data_i  (ram_rdata),
    .r_o         (r_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i)
  );

  axi_mem_burst_addr u_rd_addr (
    .req_i  (rd_req),
    .beat_i (rd_beat),
    .addr_o (rd_beat_addr)
  );

  axi_mem_ram u_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .we_i    (ram_we),
    .widx_i  (ram_widx),
    .wstrb_i (ram_wstrb),
    .wdata_i (ram_wdata),
    .ridx_i  (ram_ridx),
    .rdata_o (ram_rdata)
  );

  // W source must hold beat and last until the queue takes them
  a_w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    w_valid_i && !w_ready_o |=> w_valid_i && $stable(w_i) && $stable(w_last_i))
    else $error("W beat changed before acceptance");

endmodule

/* src/axi_mem_rd_chan.sv */
`timescale 1ns/1ps

module axi_mem_rd_chan (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  axi_mem_pkg::ax_req_t            ar_i,
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  beat_addr_i,
  output axi_mem_pkg::ax_req_t            req_o,
  output logic [axi_mem_pkg::LEN_W-1:0]   beat_o,
  output logic [axi_mem_pkg::IDX_W-1:0]   ram_idx_o,
  input  logic [axi_mem_pkg::DATA_W-1:0]  ram_data_i,
  output axi_mem_pkg::r_beat_t            r_o,
  output logic                            r_valid_o,
  input  logic                            r_ready_i
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    RD_RESET,
    RD_WAIT_ADDR,
    RD_DELAY,
    RD_SEND
  } rd_state_e;

  rd_state_e           state_r;
  rd_state_e           state_n;
  ax_req_t             req_r;
  logic [LEN_W-1:0]    beat_r;
  logic [RD_DLY_W-1:0] dly_r;
  logic                ar_fire;
  logic                r_fire;
  logic                last_beat;

  assign ar_ready_o = (state_r == RD_WAIT_ADDR);
  assign ar_fire    = ar_valid_i && ar_ready_o;
  assign r_valid_o  = (state_r == RD_SEND);
  assign r_fire     = r_valid_o && r_ready_i;
  assign last_beat  = (beat_r == req_r.len);

  assign req_o     = req_r;
  assign beat_o    = beat_r;
  assign ram_idx_o = beat_addr_i[BYTE_OFFS_W +: IDX_W];

  assign r_o.id   = req_r.id;
  assign r_o.data = ram_data_i;
  assign r_o.resp = RESP_OKAY;
  assign r_o.last = last_beat;

  always_comb begin
    state_n = state_r;
    case (state_r)
      RD_RESET: begin
        state_n = RD_WAIT_ADDR;
      end
      RD_WAIT_ADDR: begin
        if (ar_valid_i) begin
          state_n = (RD_DELAY == 0) ? RD_SEND : RD_DELAY;
        end
      end
      RD_DELAY: begin
        if (dly_r == RD_DLY_W'(RD_DLY_MAX)) begin
          state_n = RD_SEND;
        end
      end
      RD_SEND: begin
        if (r_fire && last_beat) begin
          state_n = RD_WAIT_ADDR;
        end
      end
      default: begin
        state_n = RD_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RD_RESET;
      beat_r  <= '0;
      dly_r   <= '0;
    end else begin
      state_r <= state_n;
      // Beat only moves on a transfer, so a stall holds address and data
      if (ar_fire) begin
        beat_r <= '0;
      end else if (r_fire) begin
        beat_r <= beat_r + 1'b1;
      end
      if (state_r == RD_DELAY) begin
        dly_r <= dly_r + 1'b1;
      end else begin
        dly_r <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      req_r <= ar_i;
    end
  end

  a_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R beat changed while stalled");

endmodule

/* src/axi_mem_wr_chan.sv */
`timescale 1ns/1ps

module axi_mem_wr_chan (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  axi_mem_pkg::ax_req_t            aw_i,
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  axi_mem_pkg::w_beat_t            wq_i,
  input  logic                            wq_valid_i,
  output logic                            wq_ready_o,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  beat_addr_i,
  output axi_mem_pkg::ax_req_t            req_o,
  output logic [axi_mem_pkg::LEN_W-1:0]   beat_o,
  output axi_mem_pkg::b_resp_t            b_o,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  output logic                            ram_we_o,
  output logic [axi_mem_pkg::IDX_W-1:0]   ram_idx_o,
  output logic [axi_mem_pkg::STRB_W-1:0]  ram_strb_o,
  output logic [axi_mem_pkg::DATA_W-1:0]  ram_data_o
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    WR_RESET,
    WR_WAIT_ADDR,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e           state_r;
  wr_state_e           state_n;
  ax_req_t             req_r;
  logic [LEN_W-1:0]    beat_r;
  logic [WR_DLY_W-1:0] dly_r;
  logic                dly_done;
  logic                aw_fire;
  logic                pop;

  assign dly_done   = (dly_r == WR_DLY_W'(WR_DLY_MAX));
  assign aw_ready_o = (state_r == WR_WAIT_ADDR);
  assign aw_fire    = aw_valid_i && aw_ready_o;
  // Queue drains one beat per cycle once the delay has run out
  assign wq_ready_o = (state_r == WR_WAIT_DATA) && dly_done;
  assign pop        = wq_valid_i && wq_ready_o;

  assign req_o  = req_r;
  assign beat_o = beat_r;

  assign ram_we_o   = pop;
  assign ram_idx_o  = beat_addr_i[BYTE_OFFS_W +: IDX_W];
  assign ram_strb_o = wq_i.strb;
  assign ram_data_o = wq_i.data;

  assign b_valid_o = (state_r == WR_RESP);
  assign b_o.id    = req_r.id;
  assign b_o.resp  = RESP_OKAY;

  always_comb begin
    state_n = state_r;
    case (state_r)
      WR_RESET: begin
        state_n = WR_WAIT_ADDR;
      end
      WR_WAIT_ADDR: begin
        if (aw_valid_i) begin
          state_n = WR_WAIT_DATA;
        end
      end
      WR_WAIT_DATA: begin
        if (pop && (beat_r == req_r.len)) begin
          state_n = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_ready_i) begin
          state_n = WR_WAIT_ADDR;
        end
      end
      default: begin
        state_n = WR_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= WR_RESET;
      beat_r  <= '0;
      dly_r   <= '0;
    end else begin
      state_r <= state_n;
      if (aw_fire) begin
        beat_r <= '0;
      end else if (pop) begin
        beat_r <= beat_r + 1'b1;
      end
      // Cleared while idle, saturating count once a burst is open
      if (state_r == WR_WAIT_ADDR) begin
        dly_r <= '0;
      end else if ((state_r == WR_WAIT_DATA) && !dly_done) begin
        dly_r <= dly_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      req_r <= aw_i;
    end
  end

  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else $error("B response withdrawn before b_ready_i");

endmodule

/* src/axi_mem_ram.sv */
`timescale 1ns/1ps

module axi_mem_ram (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             we_i,
  input  logic [axi_mem_pkg::IDX_W-1:0]    widx_i,
  input  logic [axi_mem_pkg::STRB_W-1:0]   wstrb_i,
  input  logic [axi_mem_pkg::DATA_W-1:0]   wdata_i,
  input  logic [axi_mem_pkg::IDX_W-1:0]    ridx_i,
  output logic [axi_mem_pkg::DATA_W-1:0]   rdata_o
);
  import axi_mem_pkg::*;

  logic [DATA_W-1:0] mem [MEM_ELS];
  // One flag per byte, set once that byte has been written
  logic [STRB_W-1:0] written_r [MEM_ELS];

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < STRB_W; b++) begin
      if (we_i && wstrb_i[b]) begin
        mem[widx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < MEM_ELS; i++) begin
        written_r[i] <= '0;
      end
    end else if (we_i) begin
      written_r[widx_i] <= written_r[widx_i] | wstrb_i;
    end
  end

  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      rdata_o[b*8 +: 8] = written_r[ridx_i][b] ? mem[ridx_i][b*8 +: 8]
                                               : INIT_DATA[b*8 +: 8];
    end
  end

endmodule

/* src/axi_mem_burst_addr.sv */
`timescale 1ns/1ps

module axi_mem_burst_addr (
  input  axi_mem_pkg::ax_req_t            req_i,
  input  logic [axi_mem_pkg::LEN_W-1:0]   beat_i,
  output logic [axi_mem_pkg::ADDR_W-1:0]  addr_o
);
  import axi_mem_pkg::*;

  logic [ADDR_W-1:0] beat_offs;
  logic [ADDR_W-1:0] incr_addr;
  logic [ADDR_W-1:0] wrap_bytes;
  logic [ADDR_W-1:0] wrap_mask;
  logic [ADDR_W-1:0] wrap_addr;

  assign beat_offs = ADDR_W'(beat_i) << BYTE_OFFS_W;
  assign incr_addr = req_i.addr + beat_offs;

  // Window is (len+1) beats wide and aligned to its own size
  assign wrap_bytes = (ADDR_W'(req_i.len) + 1'b1) << BYTE_OFFS_W;
  assign wrap_mask  = wrap_bytes - 1'b1;
  assign wrap_addr  = (req_i.addr & ~wrap_mask) | (incr_addr & wrap_mask);

  always_comb begin
    case (req_i.burst)
      BURST_INCR: begin
        addr_o = incr_addr;
      end
      BURST_WRAP: begin
        addr_o = wrap_addr;
      end
      default: begin
        addr_o = req_i.addr;
      end
    endcase
  end

  // No clock here, so the length rule is checked as the request settles
  always_comb begin
    if (req_i.burst == BURST_WRAP) begin
      a_wrap_len: assert (req_i.len inside {8'd1, 8'd3, 8'd7, 8'd15})
        else $error("WRAP burst with illegal len %0d", req_i.len);
    end
  end

endmodule

/* src/axi_mem_fifo.sv */
`timescale 1ns/1ps

module axi_mem_fifo (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  axi_mem_pkg::w_beat_t data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output axi_mem_pkg::w_beat_t data_o,
  output logic                 valid_o,
  input  logic                 ready_i
);
  import axi_mem_pkg::*;

  w_beat_t               mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_r;
  logic [FIFO_PTR_W-1:0] rd_ptr_r;
  logic [FIFO_CNT_W-1:0] count_r;
  logic                  push;
  logic                  pop;

  assign ready_o = (count_r != FIFO_CNT_W'(FIFO_DEPTH));
  assign valid_o = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push && !pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop && !push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // Occupancy agrees with the distance between the pointers
  a_count_ptrs: assert property (@(posedge clk_i) disable iff (reset_i)
    (int'(count_r) % FIFO_DEPTH) ==
      ((int'(wr_ptr_r) + FIFO_DEPTH - int'(rd_ptr_r)) % FIFO_DEPTH))
    else $error("write queue count out of step with its pointers");

endmodule

/* src/axi_mem_pkg.sv */
package axi_mem_pkg;

  // ************************************************************
  // Widths and sizes
  // ************************************************************
  localparam int ID_W        = 4;
  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int LEN_W       = 8;
  localparam int MEM_ELS     = 256;
  localparam int IDX_W       = $clog2(MEM_ELS);
  localparam int BYTE_OFFS_W = $clog2(STRB_W);

  // ************************************************************
  // Latencies and fill pattern
  // ************************************************************
  localparam int WR_DELAY   = 2;
  localparam int RD_DELAY   = 2;
  localparam int WR_DLY_MAX = (WR_DELAY > 0) ? WR_DELAY - 1 : 0;
  localparam int RD_DLY_MAX = (RD_DELAY > 0) ? RD_DELAY - 1 : 0;
  // One spare bit keeps both counters at least one bit wide
  localparam int WR_DLY_W   = $clog2(WR_DELAY + 2);
  localparam int RD_DLY_W   = $clog2(RD_DELAY + 2);

  // Write beat queue
  localparam int FIFO_DEPTH = WR_DELAY + 1;
  localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [DATA_W-1:0] INIT_DATA = 32'hdeadbeef;
  localparam logic [1:0]        RESP_OKAY = 2'b00;

  // ************************************************************
  // Channel types
  // ************************************************************
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } burst_e;

  // Shared by AW and AR, len is beat count minus 1
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    burst_e            burst;
  } ax_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_beat_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_resp_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_beat_t;

endpackage
